//--- rtl/rob_pkg.sv
// Reorder buffer package with default geometry and retire mapping field widths
package rob_pkg;

    // ------------------------------------------------------------------------
    // Buffer geometry defaults
    // ------------------------------------------------------------------------
    // Entries in the circular buffer
    localparam int ROB_ENTRY_NUM = 8;
    // Instructions accepted per cycle
    localparam int DP_NUM = 2;
    // Instructions retired per cycle
    localparam int RT_NUM = 2;
    // Result broadcast channels
    localparam int CDB_NUM = 2;

    // ------------------------------------------------------------------------
    // Retire mapping fields
    // ------------------------------------------------------------------------
    // Architectural destination register index
    localparam int ARCH_REG_IDX_WIDTH = 5;
    // Physical register tag, new and previous mapping
    localparam int TAG_WIDTH = 6;
    // Branch target address
    localparam int XLEN = 32;

endpackage

//--- rtl/rob_ptr_ctrl.sv
// Reorder buffer head/tail pointer control with wrap bits and free-entry count
`timescale 1ns/1ps

module rob_ptr_ctrl #(
    parameter int  C_ROB_ENTRY_NUM = rob_pkg::ROB_ENTRY_NUM,
    parameter int  C_DP_NUM        = rob_pkg::DP_NUM,
    parameter int  C_RT_NUM        = rob_pkg::RT_NUM,
    localparam int C_IDX_W         = $clog2(C_ROB_ENTRY_NUM),
    localparam int C_DP_CNT_W      = $clog2(C_DP_NUM + 1),
    localparam int C_RT_CNT_W      = $clog2(C_RT_NUM + 1)
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [C_DP_CNT_W-1:0]              dp_num_i,
    input  logic [C_RT_CNT_W-1:0]              rt_num_i,
    input  logic                               flush_i,
    output logic [C_IDX_W-1:0]                 head_o,
    output logic [C_IDX_W-1:0]                 tail_o,
    output logic [C_DP_CNT_W-1:0]              avail_num_o,
    output logic [C_DP_NUM-1:0][C_IDX_W-1:0]   dp_rob_idx_o
);

    // Extra bit holds pointer plus count before the wrap
    localparam int                 C_SUM_W = C_IDX_W + 1;
    localparam logic [C_SUM_W-1:0] C_DEPTH = C_SUM_W'(C_ROB_ENTRY_NUM);

    logic [C_IDX_W-1:0] head_q;
    logic [C_IDX_W-1:0] tail_q;
    logic               head_wrap_q;
    logic               tail_wrap_q;
    logic [C_SUM_W-1:0] head_sum;
    logic [C_SUM_W-1:0] tail_sum;
    logic               head_cross;
    logic               tail_cross;
    logic [C_SUM_W-1:0] used_num;
    logic [C_SUM_W-1:0] free_num;

    // ------------------------------------------------------------------------
    // Pointer update
    // ------------------------------------------------------------------------
    always_comb begin
        head_sum   = C_SUM_W'(head_q) + C_SUM_W'(rt_num_i);
        tail_sum   = C_SUM_W'(tail_q) + C_SUM_W'(dp_num_i);
        head_cross = head_sum >= C_DEPTH;
        tail_cross = tail_sum >= C_DEPTH;
    end

    always_ff @(posedge clk_i) begin
        // Flush restarts both pointers at entry 0
        if (rst_i || flush_i) begin
            head_q      <= '0;
            tail_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_wrap_q <= 1'b0;
        end else begin
            head_q      <= C_IDX_W'(head_cross ? head_sum - C_DEPTH : head_sum);
            tail_q      <= C_IDX_W'(tail_cross ? tail_sum - C_DEPTH : tail_sum);
            // Wrap bit flips on each pass over the last entry
            head_wrap_q <= head_wrap_q ^ head_cross;
            tail_wrap_q <= tail_wrap_q ^ tail_cross;
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

    // ------------------------------------------------------------------------
    // Occupancy and dispatch indices
    // ------------------------------------------------------------------------
    always_comb begin
        logic [C_SUM_W-1:0] slot_sum;
        // Same lap means tail is ahead of head in plain order
        if (head_wrap_q == tail_wrap_q) begin
            used_num = C_SUM_W'(tail_q) - C_SUM_W'(head_q);
        end else begin
            used_num = C_DEPTH - C_SUM_W'(head_q) + C_SUM_W'(tail_q);
        end
        // Entries leaving this cycle count as free
        free_num = C_DEPTH - used_num + C_SUM_W'(rt_num_i);
        if (free_num > C_SUM_W'(C_DP_NUM)) begin
            avail_num_o = C_DP_CNT_W'(C_DP_NUM);
        end else begin
            avail_num_o = C_DP_CNT_W'(free_num);
        end
        // Slot i lands i entries past tail
        for (int i = 0; i < C_DP_NUM; i++) begin
            slot_sum        = C_SUM_W'(tail_q) + C_SUM_W'(i);
            dp_rob_idx_o[i] = C_IDX_W'(slot_sum >= C_DEPTH ? slot_sum - C_DEPTH : slot_sum);
        end
    end

    // Dispatcher never overruns the advertised space
    a_dp_within_free: assert property (@(posedge clk_i) disable iff (rst_i)
        dp_num_i <= avail_num_o);

    // Retire selection never runs past the occupied entries
    a_rt_within_used: assert property (@(posedge clk_i) disable iff (rst_i)
        C_SUM_W'(rt_num_i) <= used_num);

endmodule

//--- rtl/rob_entry_array.sv
// Reorder buffer entry storage with dispatch, completion, retire clear and slot read
`timescale 1ns/1ps

module rob_entry_array #(
    parameter int  C_ROB_ENTRY_NUM = rob_pkg::ROB_ENTRY_NUM,
    parameter int  C_DP_NUM        = rob_pkg::DP_NUM,
    parameter int  C_RT_NUM        = rob_pkg::RT_NUM,
    parameter int  C_CDB_NUM       = rob_pkg::CDB_NUM,
    localparam int C_IDX_W         = $clog2(C_ROB_ENTRY_NUM),
    localparam int C_DP_CNT_W      = $clog2(C_DP_NUM + 1),
    localparam int C_RT_CNT_W      = $clog2(C_RT_NUM + 1)
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic [C_IDX_W-1:0]                                  head_i,
    input  logic [C_IDX_W-1:0]                                  tail_i,
    input  logic [C_DP_CNT_W-1:0]                               dp_num_i,
    input  logic [C_DP_NUM-1:0][rob_pkg::ARCH_REG_IDX_WIDTH-1:0] dp_rd_i,
    input  logic [C_DP_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          dp_tag_i,
    input  logic [C_DP_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          dp_tag_old_i,
    input  logic [C_DP_NUM-1:0]                                 dp_br_predict_i,
    input  logic [C_CDB_NUM-1:0]                                cdb_valid_i,
    input  logic [C_CDB_NUM-1:0][C_IDX_W-1:0]                   cdb_rob_idx_i,
    input  logic [C_CDB_NUM-1:0]                                cdb_br_result_i,
    input  logic [C_CDB_NUM-1:0][rob_pkg::XLEN-1:0]             cdb_br_target_i,
    input  logic [C_RT_CNT_W-1:0]                               rt_num_i,
    input  logic                                                flush_i,
    output logic [C_RT_NUM-1:0]                                 slot_valid_o,
    output logic [C_RT_NUM-1:0]                                 slot_complete_o,
    output logic [C_RT_NUM-1:0]                                 slot_mispredict_o,
    output logic [C_RT_NUM-1:0][rob_pkg::XLEN-1:0]              slot_br_target_o,
    output logic [C_RT_NUM-1:0][rob_pkg::ARCH_REG_IDX_WIDTH-1:0] slot_rd_o,
    output logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          slot_tag_o,
    output logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          slot_tag_old_o
);

    import rob_pkg::*;

    localparam int                 C_SUM_W     = C_IDX_W + 1;
    localparam logic [C_SUM_W-1:0] C_DEPTH     = C_SUM_W'(C_ROB_ENTRY_NUM);
    localparam int                 C_DP_IDX_W  = (C_DP_NUM > 1) ? $clog2(C_DP_NUM) : 1;
    localparam int                 C_CDB_IDX_W = (C_CDB_NUM > 1) ? $clog2(C_CDB_NUM) : 1;

    // Per-entry status
    logic [C_ROB_ENTRY_NUM-1:0]                         valid_q;
    logic [C_ROB_ENTRY_NUM-1:0]                         complete_q;
    // Per-entry payload
    logic [C_ROB_ENTRY_NUM-1:0]                         br_predict_q;
    logic [C_ROB_ENTRY_NUM-1:0]                         br_result_q;
    logic [C_ROB_ENTRY_NUM-1:0][XLEN-1:0]               br_target_q;
    logic [C_ROB_ENTRY_NUM-1:0][ARCH_REG_IDX_WIDTH-1:0] rd_q;
    logic [C_ROB_ENTRY_NUM-1:0][TAG_WIDTH-1:0]          tag_q;
    logic [C_ROB_ENTRY_NUM-1:0][TAG_WIDTH-1:0]          tag_old_q;

    logic [C_ROB_ENTRY_NUM-1:0]                         dp_sel;
    logic [C_ROB_ENTRY_NUM-1:0][C_DP_IDX_W-1:0]         dp_slot;
    logic [C_ROB_ENTRY_NUM-1:0]                         rt_sel;
    logic [C_ROB_ENTRY_NUM-1:0]                         cp_sel;
    logic [C_ROB_ENTRY_NUM-1:0][C_CDB_IDX_W-1:0]        cp_ch;

    // Forward distance from base to entry around the ring
    function automatic logic [C_SUM_W-1:0] ring_dist(input logic [C_IDX_W-1:0] entry,
                                                     input logic [C_IDX_W-1:0] base);
        if (entry >= base) begin
            return C_SUM_W'(entry) - C_SUM_W'(base);
        end else begin
            return C_DEPTH + C_SUM_W'(entry) - C_SUM_W'(base);
        end
    endfunction

    // ------------------------------------------------------------------------
    // Per-entry dispatch, retire and completion selects
    // ------------------------------------------------------------------------
    always_comb begin
        logic [C_SUM_W-1:0] dp_off;
        logic [C_SUM_W-1:0] rt_off;
        for (int e = 0; e < C_ROB_ENTRY_NUM; e++) begin
            // Dispatch window starts at tail, offset is the slot number
            dp_off     = ring_dist(C_IDX_W'(e), tail_i);
            dp_sel[e]  = dp_off < C_SUM_W'(dp_num_i);
            dp_slot[e] = C_DP_IDX_W'(dp_off);
            // Retire window starts at head
            rt_off     = ring_dist(C_IDX_W'(e), head_i);
            rt_sel[e]  = rt_off < C_SUM_W'(rt_num_i);
            // Highest matching channel wins
            cp_sel[e]  = 1'b0;
            cp_ch[e]   = '0;
            for (int c = 0; c < C_CDB_NUM; c++) begin
                if (cdb_valid_i[c] && cdb_rob_idx_i[c] == C_IDX_W'(e)) begin
                    cp_sel[e] = 1'b1;
                    cp_ch[e]  = C_CDB_IDX_W'(c);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Storage update
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_q    <= '0;
            complete_q <= '0;
        end else begin
            for (int e = 0; e < C_ROB_ENTRY_NUM; e++) begin
                // Dispatch first, may reuse an entry retiring now
                if (dp_sel[e]) begin
                    valid_q[e]    <= 1'b1;
                    complete_q[e] <= 1'b0;
                end else if (rt_sel[e]) begin
                    valid_q[e]    <= 1'b0;
                    complete_q[e] <= 1'b0;
                end else if (cp_sel[e] && valid_q[e]) begin
                    complete_q[e] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int e = 0; e < C_ROB_ENTRY_NUM; e++) begin
            if (dp_sel[e]) begin
                rd_q[e]         <= dp_rd_i[dp_slot[e]];
                tag_q[e]        <= dp_tag_i[dp_slot[e]];
                tag_old_q[e]    <= dp_tag_old_i[dp_slot[e]];
                br_predict_q[e] <= dp_br_predict_i[dp_slot[e]];
            end
            // Branch outcome arrives with completion
            if (cp_sel[e] && valid_q[e]) begin
                br_result_q[e]  <= cdb_br_result_i[cp_ch[e]];
                br_target_q[e]  <= cdb_br_target_i[cp_ch[e]];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Head-relative slot read
    // ------------------------------------------------------------------------
    always_comb begin
        logic [C_SUM_W-1:0] sum;
        logic [C_IDX_W-1:0] idx;
        for (int s = 0; s < C_RT_NUM; s++) begin
            sum                  = C_SUM_W'(head_i) + C_SUM_W'(s);
            idx                  = C_IDX_W'(sum >= C_DEPTH ? sum - C_DEPTH : sum);
            slot_valid_o[s]      = valid_q[idx];
            slot_complete_o[s]   = complete_q[idx];
            // Non-branches carry 0 for both, so never mispredict
            slot_mispredict_o[s] = br_predict_q[idx] != br_result_q[idx];
            slot_br_target_o[s]  = br_target_q[idx];
            slot_rd_o[s]         = rd_q[idx];
            slot_tag_o[s]        = tag_q[idx];
            slot_tag_old_o[s]    = tag_old_q[idx];
        end
    end

    // Completion stage only reports instructions still in flight
    for (genvar c = 0; c < C_CDB_NUM; c++) begin : g_cdb_chk
        a_cdb_live: assert property (@(posedge clk_i) disable iff (rst_i)
            cdb_valid_i[c] |-> valid_q[cdb_rob_idx_i[c]]);
    end

endmodule

//--- rtl/rob_retire_sel.sv
// Reorder buffer in-order retire chain with misprediction detection and flush
`timescale 1ns/1ps

module rob_retire_sel #(
    parameter int  C_RT_NUM   = rob_pkg::RT_NUM,
    localparam int C_RT_CNT_W = $clog2(C_RT_NUM + 1)
) (
    input  logic [C_RT_NUM-1:0]                                 slot_valid_i,
    input  logic [C_RT_NUM-1:0]                                 slot_complete_i,
    input  logic [C_RT_NUM-1:0]                                 slot_mispredict_i,
    input  logic [C_RT_NUM-1:0][rob_pkg::XLEN-1:0]              slot_br_target_i,
    input  logic [C_RT_NUM-1:0][rob_pkg::ARCH_REG_IDX_WIDTH-1:0] slot_rd_i,
    input  logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          slot_tag_i,
    input  logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          slot_tag_old_i,
    input  logic                                                exception_i,
    output logic [C_RT_NUM-1:0]                                 rt_valid_o,
    output logic [C_RT_CNT_W-1:0]                               rt_num_o,
    output logic [C_RT_NUM-1:0][rob_pkg::ARCH_REG_IDX_WIDTH-1:0] rt_arch_reg_o,
    output logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          rt_tag_o,
    output logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          rt_tag_old_o,
    output logic                                                br_mis_valid_o,
    output logic [rob_pkg::XLEN-1:0]                            br_target_o,
    output logic                                                flush_o
);

    // ------------------------------------------------------------------------
    // Retire chain from the head slot
    // ------------------------------------------------------------------------
    always_comb begin
        logic chain;
        logic rt_ok;
        chain          = 1'b1;
        rt_valid_o     = '0;
        rt_num_o       = '0;
        br_mis_valid_o = 1'b0;
        br_target_o    = '0;
        for (int s = 0; s < C_RT_NUM; s++) begin
            // Needs every older slot in the window retiring too
            rt_ok         = chain & slot_valid_i[s] & slot_complete_i[s];
            rt_valid_o[s] = rt_ok;
            if (rt_ok) begin
                rt_num_o = rt_num_o + C_RT_CNT_W'(1);
                // Mispredicted branch still retires itself
                if (slot_mispredict_i[s]) begin
                    br_mis_valid_o = 1'b1;
                    br_target_o    = slot_br_target_i[s];
                end
            end
            // Younger slots stop behind a mispredict
            chain = rt_ok & ~slot_mispredict_i[s];
        end
    end

    // Mappings go to the map table and free list, qualified by rt_valid_o
    assign rt_arch_reg_o = slot_rd_i;
    assign rt_tag_o      = slot_tag_i;
    assign rt_tag_old_o  = slot_tag_old_i;

    // Whole buffer drops on a retiring mispredict or an exception
    assign flush_o = br_mis_valid_o | exception_i;

endmodule

//--- rtl/rob_top.sv
// Reorder buffer top level joining pointer control, entry array and retire select
`timescale 1ns/1ps

module rob_top #(
    parameter int  C_ROB_ENTRY_NUM = rob_pkg::ROB_ENTRY_NUM,
    parameter int  C_DP_NUM        = rob_pkg::DP_NUM,
    parameter int  C_RT_NUM        = rob_pkg::RT_NUM,
    parameter int  C_CDB_NUM       = rob_pkg::CDB_NUM,
    localparam int C_IDX_W         = $clog2(C_ROB_ENTRY_NUM),
    localparam int C_DP_CNT_W      = $clog2(C_DP_NUM + 1),
    localparam int C_RT_CNT_W      = $clog2(C_RT_NUM + 1)
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    // Dispatch
    output logic [C_DP_CNT_W-1:0]                               avail_num_o,
    output logic [C_DP_NUM-1:0][C_IDX_W-1:0]                    dp_rob_idx_o,
    input  logic [C_DP_CNT_W-1:0]                               dp_num_i,
    input  logic [C_DP_NUM-1:0][rob_pkg::ARCH_REG_IDX_WIDTH-1:0] dp_rd_i,
    input  logic [C_DP_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          dp_tag_i,
    input  logic [C_DP_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          dp_tag_old_i,
    input  logic [C_DP_NUM-1:0]                                 dp_br_predict_i,
    // Result broadcast
    input  logic [C_CDB_NUM-1:0]                                cdb_valid_i,
    input  logic [C_CDB_NUM-1:0][C_IDX_W-1:0]                   cdb_rob_idx_i,
    input  logic [C_CDB_NUM-1:0]                                cdb_br_result_i,
    input  logic [C_CDB_NUM-1:0][rob_pkg::XLEN-1:0]             cdb_br_target_i,
    // Retire to map table and free list
    output logic [C_RT_NUM-1:0]                                 rt_valid_o,
    output logic [C_RT_CNT_W-1:0]                               rt_num_o,
    output logic [C_RT_NUM-1:0][rob_pkg::ARCH_REG_IDX_WIDTH-1:0] rt_arch_reg_o,
    output logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          rt_tag_o,
    output logic [C_RT_NUM-1:0][rob_pkg::TAG_WIDTH-1:0]          rt_tag_old_o,
    // Redirect
    output logic                                                br_mis_valid_o,
    output logic [rob_pkg::XLEN-1:0]                            br_target_o,
    input  logic                                                exception_i
);

    import rob_pkg::*;

    logic [C_IDX_W-1:0]                         head;
    logic [C_IDX_W-1:0]                         tail;
    logic                                       flush;
    // Head-relative view of the retire window
    logic [C_RT_NUM-1:0]                        slot_valid;
    logic [C_RT_NUM-1:0]                        slot_complete;
    logic [C_RT_NUM-1:0]                        slot_mispredict;
    logic [C_RT_NUM-1:0][XLEN-1:0]              slot_br_target;
    logic [C_RT_NUM-1:0][ARCH_REG_IDX_WIDTH-1:0] slot_rd;
    logic [C_RT_NUM-1:0][TAG_WIDTH-1:0]          slot_tag;
    logic [C_RT_NUM-1:0][TAG_WIDTH-1:0]          slot_tag_old;

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------
    rob_ptr_ctrl #(
        .C_ROB_ENTRY_NUM (C_ROB_ENTRY_NUM),
        .C_DP_NUM        (C_DP_NUM),
        .C_RT_NUM        (C_RT_NUM)
    ) rob_ptr_ctrl_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dp_num_i     (dp_num_i),
        .rt_num_i     (rt_num_o),
        .flush_i      (flush),
        .head_o       (head),
        .tail_o       (tail),
        .avail_num_o  (avail_num_o),
        .dp_rob_idx_o (dp_rob_idx_o)
    );

    rob_entry_array #(
        .C_ROB_ENTRY_NUM (C_ROB_ENTRY_NUM),
        .C_DP_NUM        (C_DP_NUM),
        .C_RT_NUM        (C_RT_NUM),
        .C_CDB_NUM       (C_CDB_NUM)
    ) rob_entry_array_inst (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .head_i            (head),
        .tail_i            (tail),
        .dp_num_i          (dp_num_i),
        .dp_rd_i           (dp_rd_i),
        .dp_tag_i          (dp_tag_i),
        .dp_tag_old_i      (dp_tag_old_i),
        .dp_br_predict_i   (dp_br_predict_i),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_rob_idx_i     (cdb_rob_idx_i),
        .cdb_br_result_i   (cdb_br_result_i),
        .cdb_br_target_i   (cdb_br_target_i),
        .rt_num_i          (rt_num_o),
        .flush_i           (flush),
        .slot_valid_o      (slot_valid),
        .slot_complete_o   (slot_complete),
        .slot_mispredict_o (slot_mispredict),
        .slot_br_target_o  (slot_br_target),
        .slot_rd_o         (slot_rd),
        .slot_tag_o        (slot_tag),
        .slot_tag_old_o    (slot_tag_old)
    );

    rob_retire_sel #(
        .C_RT_NUM (C_RT_NUM)
    ) rob_retire_sel_inst (
        .slot_valid_i      (slot_valid),
        .slot_complete_i   (slot_complete),
        .slot_mispredict_i (slot_mispredict),
        .slot_br_target_i  (slot_br_target),
        .slot_rd_i         (slot_rd),
        .slot_tag_i        (slot_tag),
        .slot_tag_old_i    (slot_tag_old),
        .exception_i       (exception_i),
        .rt_valid_o        (rt_valid_o),
        .rt_num_o          (rt_num_o),
        .rt_arch_reg_o     (rt_arch_reg_o),
        .rt_tag_o          (rt_tag_o),
        .rt_tag_old_o      (rt_tag_old_o),
        .br_mis_valid_o    (br_mis_valid_o),
        .br_target_o       (br_target_o),
        .flush_o           (flush)
    );

endmodule

//--- tb/rob_tb_table.svh
// Reorder buffer stimulus and expected-value table, one row per cycle
// test, dp_num, rd/tag/pred slot0, rd/tag/pred slot1, cdb valid mask, cdb idx0/idx1,
// cdb result mask, cdb target0/1, exception | avail, idx0, rt_num, rd/tag rt0, rd/tag rt1, mis, tgt
// After reset
tab[0]  = '{1, 0,  0, 0, 0,  0, 0, 0, 0, 0, 0, 0,     0, 0, 0, 2, 0, 0,  0, 0,  0, 0, 0,     0};
// Out-of-order completion, in-order retire
tab[1]  = '{2, 2,  1,11, 0,  2,12, 0, 0, 0, 0, 0,     0, 0, 0, 2, 0, 0,  0, 0,  0, 0, 0,     0};
tab[2]  = '{2, 2,  3,13, 0,  4,14, 0, 0, 0, 0, 0,     0, 0, 0, 2, 2, 0,  0, 0,  0, 0, 0,     0};
tab[3]  = '{2, 0,  0, 0, 0,  0, 0, 0, 1, 1, 0, 0,     0, 0, 0, 2, 4, 0,  0, 0,  0, 0, 0,     0};
tab[4]  = '{2, 0,  0, 0, 0,  0, 0, 0, 1, 0, 0, 0,     0, 0, 0, 2, 4, 0,  0, 0,  0, 0, 0,     0};
tab[5]  = '{2, 0,  0, 0, 0,  0, 0, 0, 0, 0, 0, 0,     0, 0, 0, 2, 4, 2,  1,11,  2,12, 0,     0};
// Retire width limit
tab[6]  = '{3, 1,  5,15, 0,  0, 0, 0, 1, 3, 0, 0,     0, 0, 0, 2, 4, 0,  0, 0,  0, 0, 0,     0};
tab[7]  = '{3, 0,  0, 0, 0,  0, 0, 0, 3, 4, 2, 0,     0, 0, 0, 2, 5, 0,  0, 0,  0, 0, 0,     0};
tab[8]  = '{3, 0,  0, 0, 0,  0, 0, 0, 0, 0, 0, 0,     0, 0, 0, 2, 5, 2,  3,13,  4,14, 0,     0};
tab[9]  = '{3, 0,  0, 0, 0,  0, 0, 0, 0, 0, 0, 0,     0, 0, 0, 2, 5, 1,  5,15,  0, 0, 0,     0};
// Full buffer and pointer wrap
tab[10] = '{4, 2,  6,16, 0,  7,17, 0, 0, 0, 0, 0,     0, 0, 0, 2, 5, 0,  0, 0,  0, 0, 0,     0};
tab[11] = '{4, 2,  8,18, 0,  9,19, 0, 0, 0, 0, 0,     0, 0, 0, 2, 7, 0,  0, 0,  0, 0, 0,     0};
tab[12] = '{4, 2, 10,20, 0, 11,21, 0, 0, 0, 0, 0,     0, 0, 0, 2, 1, 0,  0, 0,  0, 0, 0,     0};
tab[13] = '{4, 2, 12,22, 0, 13,23, 0, 0, 0, 0, 0,     0, 0, 0, 2, 3, 0,  0, 0,  0, 0, 0,     0};
tab[14] = '{4, 0,  0, 0, 0,  0, 0, 0, 3, 5, 6, 0,     0, 0, 0, 0, 5, 0,  0, 0,  0, 0, 0,     0};
tab[15] = '{4, 2, 14,24, 0, 15,25, 0, 0, 0, 0, 0,     0, 0, 0, 2, 5, 2,  6,16,  7,17, 0,     0};
// Misprediction flush
tab[16] = '{5, 0,  0, 0, 0,  0, 0, 0, 3, 0, 1, 1, 'h240, 0, 0, 0, 7, 0,  0, 0,  0, 0, 0,     0};
tab[17] = '{5, 0,  0, 0, 0,  0, 0, 0, 1, 7, 0, 0,     0, 0, 0, 0, 7, 0,  0, 0,  0, 0, 0,     0};
tab[18] = '{5, 0,  0, 0, 0,  0, 0, 0, 0, 0, 0, 0,     0, 0, 0, 2, 7, 2,  8,18,  9,19, 1, 'h240};
tab[19] = '{5, 2, 16,26, 1, 17,27, 0, 0, 0, 0, 0,     0, 0, 0, 2, 0, 0,  0, 0,  0, 0, 0,     0};
tab[20] = '{5, 0,  0, 0, 0,  0, 0, 0, 3, 0, 1, 0, 'h380, 0, 0, 2, 2, 0,  0, 0,  0, 0, 0,     0};
tab[21] = '{5, 0,  0, 0, 0,  0, 0, 0, 0, 0, 0, 0,     0, 0, 0, 2, 2, 1, 16,26,  0, 0, 1, 'h380};
tab[22] = '{5, 2, 18,28, 0, 19,29, 0, 0, 0, 0, 0,     0, 0, 0, 2, 0, 0,  0, 0,  0, 0, 0,     0};
// Exception flush
tab[23] = '{6, 1, 20,30, 0,  0, 0, 0, 1, 1, 0, 0,     0, 0, 0, 2, 2, 0,  0, 0,  0, 0, 0,     0};
tab[24] = '{6, 0,  0, 0, 0,  0, 0, 0, 1, 2, 0, 0,     0, 0, 0, 2, 3, 0,  0, 0,  0, 0, 0,     0};
tab[25] = '{6, 0,  0, 0, 0,  0, 0, 0, 1, 0, 0, 0,     0, 0, 1, 2, 3, 0,  0, 0,  0, 0, 0,     0};
tab[26] = '{6, 0,  0, 0, 0,  0, 0, 0, 0, 0, 0, 0,     0, 0, 0, 2, 0, 0,  0, 0,  0, 0, 0,     0};

//--- tb/rob_tb.sv
// Reorder buffer testbench applying a per-cycle stimulus table and checking retire outputs
`timescale 1ns/1ps

module rob_tb;

    import rob_pkg::*;

    localparam int CLK_HALF   = 50;
    localparam int RST_CYCLES = 4;
    localparam int ROW_NUM    = 27;
    localparam int COL_NUM    = 24;
    localparam int CYCLE_MAX  = ROW_NUM + 10;
    localparam int IDX_W      = $clog2(ROB_ENTRY_NUM);
    localparam int DP_CNT_W   = $clog2(DP_NUM + 1);
    localparam int RT_CNT_W   = $clog2(RT_NUM + 1);
    // Previous mapping differs from the new tag in its top bit
    localparam logic [TAG_WIDTH-1:0] TAG_OLD_FLIP = 6'h20;

    logic                                       clk_i;
    logic                                       rst_i;
    logic [DP_CNT_W-1:0]                        avail_num_o;
    logic [DP_NUM-1:0][IDX_W-1:0]               dp_rob_idx_o;
    logic [DP_CNT_W-1:0]                        dp_num_i;
    logic [DP_NUM-1:0][ARCH_REG_IDX_WIDTH-1:0]  dp_rd_i;
    logic [DP_NUM-1:0][TAG_WIDTH-1:0]           dp_tag_i;
    logic [DP_NUM-1:0][TAG_WIDTH-1:0]           dp_tag_old_i;
    logic [DP_NUM-1:0]                          dp_br_predict_i;
    logic [CDB_NUM-1:0]                         cdb_valid_i;
    logic [CDB_NUM-1:0][IDX_W-1:0]              cdb_rob_idx_i;
    logic [CDB_NUM-1:0]                         cdb_br_result_i;
    logic [CDB_NUM-1:0][XLEN-1:0]               cdb_br_target_i;
    logic [RT_NUM-1:0]                          rt_valid_o;
    logic [RT_CNT_W-1:0]                        rt_num_o;
    logic [RT_NUM-1:0][ARCH_REG_IDX_WIDTH-1:0]  rt_arch_reg_o;
    logic [RT_NUM-1:0][TAG_WIDTH-1:0]           rt_tag_o;
    logic [RT_NUM-1:0][TAG_WIDTH-1:0]           rt_tag_old_o;
    logic                                       br_mis_valid_o;
    logic [XLEN-1:0]                            br_target_o;
    logic                                       exception_i;

    // One row per cycle, columns listed in the table file
    int tab [ROW_NUM][COL_NUM];
    int err_cnt;

    rob_top rob_top_inst (.*);

    // ------------------------------------------------------------------------
    // Clock
    // ------------------------------------------------------------------------
    initial begin
        clk_i = 1'b0;
        forever begin
            #CLK_HALF clk_i = ~clk_i;
        end
    end

    task automatic load_table();
        `include "rob_tb_table.svh"
    endtask

    task automatic report_err(input int r, input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        $display("ERR row %0d %s expected %h actual %h", r, name, exp_v, act_v);
        err_cnt++;
    endtask

    // Row inputs, applied on the falling edge
    task automatic drive_row(input int r);
        for (int s = 0; s < DP_NUM; s++) begin
            dp_rd_i[s]         = ARCH_REG_IDX_WIDTH'(tab[r][2 + 3 * s]);
            dp_tag_i[s]        = TAG_WIDTH'(tab[r][3 + 3 * s]);
            dp_tag_old_i[s]    = TAG_WIDTH'(tab[r][3 + 3 * s]) ^ TAG_OLD_FLIP;
            dp_br_predict_i[s] = tab[r][4 + 3 * s] != 0;
        end
        dp_num_i        = DP_CNT_W'(tab[r][1]);
        cdb_valid_i     = CDB_NUM'(tab[r][8]);
        cdb_br_result_i = CDB_NUM'(tab[r][11]);
        for (int c = 0; c < CDB_NUM; c++) begin
            cdb_rob_idx_i[c]   = IDX_W'(tab[r][9 + c]);
            cdb_br_target_i[c] = XLEN'(tab[r][12 + c]);
        end
        exception_i = tab[r][14] != 0;
    endtask

    // ------------------------------------------------------------------------
    // Output checks, just before the rising edge
    // ------------------------------------------------------------------------
    task automatic check_row(input int r);
        int rt_exp;
        rt_exp = tab[r][17];
        if (avail_num_o !== DP_CNT_W'(tab[r][15]))
            report_err(r, "avail_num_o", tab[r][15], 32'(avail_num_o));
        if (dp_rob_idx_o[0] !== IDX_W'(tab[r][16]))
            report_err(r, "dp_rob_idx_o[0]", tab[r][16], 32'(dp_rob_idx_o[0]));
        // Slot 1 sits one entry past slot 0 around the ring
        if (dp_rob_idx_o[1] !== IDX_W'((tab[r][16] + 1) % ROB_ENTRY_NUM))
            report_err(r, "dp_rob_idx_o[1]", (tab[r][16] + 1) % ROB_ENTRY_NUM,
                       32'(dp_rob_idx_o[1]));
        if (rt_num_o !== RT_CNT_W'(rt_exp))
            report_err(r, "rt_num_o", rt_exp, 32'(rt_num_o));
        // Thermometer from slot 0
        if (rt_valid_o !== RT_NUM'((1 << rt_exp) - 1))
            report_err(r, "rt_valid_o", (1 << rt_exp) - 1, 32'(rt_valid_o));
        if (br_mis_valid_o !== (tab[r][22] != 0))
            report_err(r, "br_mis_valid_o", tab[r][22], 32'(br_mis_valid_o));
        if (tab[r][22] != 0 && br_target_o !== XLEN'(tab[r][23]))
            report_err(r, "br_target_o", tab[r][23], br_target_o);
        // Mappings only matter on retiring slots
        for (int s = 0; s < rt_exp; s++) begin
            if (rt_arch_reg_o[s] !== ARCH_REG_IDX_WIDTH'(tab[r][18 + 2 * s]))
                report_err(r, "rt_arch_reg_o", tab[r][18 + 2 * s], 32'(rt_arch_reg_o[s]));
            if (rt_tag_o[s] !== TAG_WIDTH'(tab[r][19 + 2 * s]))
                report_err(r, "rt_tag_o", tab[r][19 + 2 * s], 32'(rt_tag_o[s]));
            if (rt_tag_old_o[s] !== (TAG_WIDTH'(tab[r][19 + 2 * s]) ^ TAG_OLD_FLIP))
                report_err(r, "rt_tag_old_o", 32'(TAG_WIDTH'(tab[r][19 + 2 * s]) ^ TAG_OLD_FLIP),
                           32'(rt_tag_old_o[s]));
        end
    endtask

    // ------------------------------------------------------------------------
    // Reset, then one table row per cycle
    // ------------------------------------------------------------------------
    initial begin
        int   cycle_cnt;
        int   test_cnt;
        int   test_err_base;
        logic timed_out;
        err_cnt       = 0;
        cycle_cnt     = 0;
        test_cnt      = 0;
        test_err_base = 0;
        timed_out     = 1'b0;
        load_table();
        rst_i = 1'b1;
        drive_row(0);
        dp_num_i    = '0;
        cdb_valid_i = '0;
        exception_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        for (int r = 0; r < ROW_NUM; r++) begin
            if (cycle_cnt >= CYCLE_MAX) begin
                timed_out = 1'b1;
                break;
            end
            drive_row(r);
            #(CLK_HALF - 1);
            check_row(r);
            cycle_cnt++;
            // Test ends at its last row
            if (r == ROW_NUM - 1 || tab[r + 1][0] != tab[r][0]) begin
                $display("Test %0d finished with %0d errors", tab[r][0], err_cnt - test_err_base);
                test_err_base = err_cnt;
                test_cnt++;
            end
            @(negedge clk_i);
        end
        if (timed_out) begin
            $display("Timeout: table loop ran past %0d cycles", CYCLE_MAX);
            $display("STATUS: FAIL");
        end else begin
            $display("Summary: %0d tests, %0d rows, %0d errors", test_cnt, ROW_NUM, err_cnt);
            if (err_cnt == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+tb
rtl/rob_pkg.sv
rtl/rob_ptr_ctrl.sv
rtl/rob_entry_array.sv
rtl/rob_retire_sel.sv
rtl/rob_top.sv
tb/rob_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module rob_tb -o rob_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi
out=$(./obj_dir/rob_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if printf '%s\n' "$out" | grep -q '^STATUS: PASS$'; then
    exit 0
fi
exit 1
